// ==== cobs_defines.svh ====
// ****************************************
// shared widths, depths and COBS code values
// included by the packages and the RTL modules
// ****************************************
`ifndef COBS_DEFINES_SVH
`define COBS_DEFINES_SVH

`define COBS_BYTE_W      8
`define COBS_FIFO_DEPTH  256
`define COBS_FIFO_AW     8

// a segment carries at most 254 data bytes
`define COBS_MAX_RUN     8'd254
`define COBS_CODE_FULL   8'd255
`define COBS_CODE_ZERO   8'd1
`define COBS_CODE_BAD    8'd2
`define COBS_DELIM       8'd0

`endif

// ==== stream_pkg.sv ====
// ****************************************
// byte type carried by every stream in the design
// ****************************************
`include "cobs_defines.svh"

package stream_pkg;

    // one byte on a stream
    typedef logic [`COBS_BYTE_W-1:0] byte_t;

endpackage

// ==== cobs_pkg.sv ====
// ****************************************
// COBS code type and the encoder and merger FSM states
// ****************************************
`include "cobs_defines.svh"

package cobs_pkg;

    // code byte, also used as the run counter
    typedef logic [`COBS_BYTE_W-1:0] code_t;

    typedef enum logic [1:0] {
        enc_idle,
        enc_segment,
        enc_final_zero,
        enc_append_zero
    } enc_state_t;

    typedef enum logic {
        merge_code,
        merge_data
    } merge_state_t;

endpackage

// ==== stream_if.sv ====
// ****************************************
// one valid/ready byte stream with last and user
// ****************************************
interface stream_if import stream_pkg::*; ();

    byte_t data;
    logic  valid;
    logic  ready;
    logic  last;
    logic  user;

    // producer side
    modport src (
        output data, valid, last, user,
        input  ready
    );

    // consumer side
    modport snk (
        input  data, valid, last, user,
        output ready
    );

endinterface

// ==== byte_fifo.sv ====
// ****************************************
// circular byte queue with last and user flags
// write side is a stream sink, read side a stream source
// ****************************************
`include "cobs_defines.svh"

module byte_fifo import stream_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    stream_if.snk wr,
    stream_if.src rd
);

    byte_t mem_data [`COBS_FIFO_DEPTH];
    logic  mem_last [`COBS_FIFO_DEPTH];
    logic  mem_user [`COBS_FIFO_DEPTH];

    // extra msb tells full from empty
    logic [`COBS_FIFO_AW:0] wr_ptr;
    logic [`COBS_FIFO_AW:0] rd_ptr;
    logic                   full;
    logic                   empty;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr == {~rd_ptr[`COBS_FIFO_AW], rd_ptr[`COBS_FIFO_AW-1:0]});

    assign wr.ready = !full;
    assign rd.valid = !empty;

    // head of queue is read straight from storage
    assign rd.data = mem_data[rd_ptr[`COBS_FIFO_AW-1:0]];
    assign rd.last = mem_last[rd_ptr[`COBS_FIFO_AW-1:0]];
    assign rd.user = mem_user[rd_ptr[`COBS_FIFO_AW-1:0]];

    always_ff @(posedge clk) begin
        if (wr.valid && wr.ready) begin
            mem_data[wr_ptr[`COBS_FIFO_AW-1:0]] <= wr.data;
            mem_last[wr_ptr[`COBS_FIFO_AW-1:0]] <= wr.last;
            mem_user[wr_ptr[`COBS_FIFO_AW-1:0]] <= wr.user;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr.valid && wr.ready) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd.valid && rd.ready) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

endmodule

// ==== cobs_segment_encoder.sv ====
// ****************************************
// input FSM, splits frames into segments
// writes code bytes and non-zero data bytes into two queues
// ****************************************
`include "cobs_defines.svh"

module cobs_segment_encoder import stream_pkg::*, cobs_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  byte_t s_axis_tdata,
    input  logic  s_axis_tvalid,
    input  logic  s_axis_tlast,
    input  logic  s_axis_tuser,
    output logic  s_axis_tready,
    stream_if.src code_wr,
    stream_if.src data_wr
);

    enc_state_t state;
    enc_state_t state_next;
    code_t      count;
    code_t      count_next;
    code_t      run_code;
    logic       fail;
    logic       fail_next;
    logic       take;
    logic       close_seg;

    // input only flows while collecting segment bytes
    assign s_axis_tready = code_wr.ready && data_wr.ready &&
                           (state == enc_idle || state == enc_segment);
    assign take = s_axis_tvalid && s_axis_tready;

    // a zero byte or a bad last byte ends the open segment
    assign close_seg = (s_axis_tdata == `COBS_DELIM) || (s_axis_tlast && s_axis_tuser);

    // code for the segment if the current byte joins it
    assign run_code = (state == enc_idle) ? code_t'(`COBS_CODE_ZERO + 1'b1) :
                                            code_t'(count + 1'b1);

    // data queue carries plain bytes only
    assign data_wr.last = 1'b0;
    assign data_wr.user = 1'b0;

    always_comb begin
        state_next    = state;
        count_next    = count;
        fail_next     = fail;
        code_wr.data  = `COBS_DELIM;
        code_wr.valid = 1'b0;
        code_wr.last  = 1'b0;
        code_wr.user  = 1'b0;
        data_wr.data  = s_axis_tdata;
        data_wr.valid = 1'b0;

        case (state)
            enc_idle, enc_segment: begin
                if (take) begin
                    if (close_seg) begin
                        // empty segment in idle, else the running count
                        code_wr.data  = (state == enc_idle) ? `COBS_CODE_ZERO : count;
                        code_wr.valid = 1'b1;
                        if (s_axis_tlast) begin
                            fail_next  = s_axis_tuser;
                            state_next = enc_final_zero;
                        end else begin
                            state_next = enc_idle;
                        end
                    end else begin
                        data_wr.valid = 1'b1;
                        count_next    = run_code;
                        // full run or end of frame writes the code now
                        if (s_axis_tlast || run_code == `COBS_CODE_FULL) begin
                            code_wr.data  = run_code;
                            code_wr.valid = 1'b1;
                        end
                        if (run_code == `COBS_CODE_FULL) begin
                            count_next = `COBS_CODE_ZERO;
                        end
                        state_next = s_axis_tlast ? enc_append_zero : enc_segment;
                    end
                end
            end
            enc_final_zero: begin
                if (code_wr.ready) begin
                    // trailing empty segment, or the bad marker
                    code_wr.data  = fail ? `COBS_CODE_BAD : `COBS_CODE_ZERO;
                    code_wr.user  = fail;
                    code_wr.valid = 1'b1;
                    state_next    = enc_append_zero;
                end
            end
            enc_append_zero: begin
                if (code_wr.ready) begin
                    code_wr.data  = `COBS_DELIM;
                    code_wr.last  = 1'b1;
                    code_wr.user  = fail;
                    code_wr.valid = 1'b1;
                    fail_next     = 1'b0;
                    state_next    = enc_idle;
                end
            end
            default: begin
                state_next = enc_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= enc_idle;
            count <= `COBS_CODE_ZERO;
            fail  <= 1'b0;
        end else begin
            state <= state_next;
            count <= count_next;
            fail  <= fail_next;
        end
    end

endmodule

// ==== cobs_output_merger.sv ====
// ****************************************
// output FSM, sends each code then its data bytes
// only offers a byte while the skid buffer is ready
// ****************************************
`include "cobs_defines.svh"

module cobs_output_merger import cobs_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    stream_if.snk code_rd,
    stream_if.snk data_rd,
    stream_if.src merged
);

    merge_state_t state;
    merge_state_t state_next;
    code_t        count;
    code_t        count_next;

    always_comb begin
        state_next    = state;
        count_next    = count;
        merged.data   = '0;
        merged.valid  = 1'b0;
        merged.last   = 1'b0;
        merged.user   = 1'b0;
        code_rd.ready = 1'b0;
        data_rd.ready = 1'b0;

        case (state)
            merge_code: begin
                if (merged.ready && code_rd.valid) begin
                    merged.data   = code_rd.data;
                    merged.last   = code_rd.last;
                    // bad flag only shows on the delimiter
                    merged.user   = code_rd.user && code_rd.last;
                    merged.valid  = 1'b1;
                    code_rd.ready = 1'b1;
                    count_next    = code_t'(code_rd.data - 1'b1);
                    // delimiter, empty and bad codes have no data behind them
                    if (code_rd.data == `COBS_DELIM || code_rd.data == `COBS_CODE_ZERO ||
                        code_rd.user) begin
                        state_next = merge_code;
                    end else begin
                        state_next = merge_data;
                    end
                end
            end
            merge_data: begin
                if (merged.ready && data_rd.valid) begin
                    merged.data   = data_rd.data;
                    merged.valid  = 1'b1;
                    data_rd.ready = 1'b1;
                    count_next    = code_t'(count - 1'b1);
                    if (count == code_t'(1)) begin
                        state_next = merge_code;
                    end
                end
            end
            default: begin
                state_next = merge_code;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= merge_code;
            count <= '0;
        end else begin
            state <= state_next;
            count <= count_next;
        end
    end

endmodule

// ==== output_skid_buffer.sv ====
// ****************************************
// output register with a spare slot
// upstream ready comes straight from a flop
// ****************************************
module output_skid_buffer import stream_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    stream_if.snk merged,
    output byte_t m_axis_tdata,
    output logic  m_axis_tvalid,
    output logic  m_axis_tlast,
    output logic  m_axis_tuser,
    input  logic  m_axis_tready
);

    logic  ready_reg;
    logic  ready_early;
    logic  out_valid;
    logic  out_last;
    logic  out_user;
    byte_t out_data;
    logic  tmp_valid;
    logic  tmp_last;
    logic  tmp_user;
    byte_t tmp_data;
    logic  load_out;
    logic  load_tmp;
    logic  tmp_to_out;

    assign merged.ready  = ready_reg;
    assign m_axis_tdata  = out_data;
    assign m_axis_tvalid = out_valid;
    assign m_axis_tlast  = out_last;
    assign m_axis_tuser  = out_user;

    // stay ready if downstream drains, or the spare slot cannot fill next cycle
    assign ready_early = m_axis_tready || (!tmp_valid && (!out_valid || !merged.valid));

    assign load_out   = ready_reg && (m_axis_tready || !out_valid);
    assign load_tmp   = ready_reg && !(m_axis_tready || !out_valid);
    assign tmp_to_out = !ready_reg && m_axis_tready;

    always_ff @(posedge clk) begin
        if (load_out) begin
            out_data <= merged.data;
            out_last <= merged.last;
            out_user <= merged.user;
        end else if (tmp_to_out) begin
            out_data <= tmp_data;
            out_last <= tmp_last;
            out_user <= tmp_user;
        end
        if (load_tmp) begin
            tmp_data <= merged.data;
            tmp_last <= merged.last;
            tmp_user <= merged.user;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ready_reg <= 1'b0;
            out_valid <= 1'b0;
            tmp_valid <= 1'b0;
        end else begin
            ready_reg <= ready_early;
            if (load_out) begin
                out_valid <= merged.valid;
            end else if (tmp_to_out) begin
                out_valid <= tmp_valid;
                tmp_valid <= 1'b0;
            end
            if (load_tmp) begin
                tmp_valid <= merged.valid;
            end
        end
    end

endmodule

// ==== cobs_encoder.sv ====
// ****************************************
// COBS stream encoder top with zero framing
// encoder, code and data queues, merger, output stage
// ****************************************
module cobs_encoder import stream_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  byte_t s_axis_tdata,
    input  logic  s_axis_tvalid,
    input  logic  s_axis_tlast,
    input  logic  s_axis_tuser,
    output logic  s_axis_tready,
    output byte_t m_axis_tdata,
    output logic  m_axis_tvalid,
    output logic  m_axis_tlast,
    output logic  m_axis_tuser,
    input  logic  m_axis_tready
);

    stream_if code_wr ();
    stream_if data_wr ();
    stream_if code_rd ();
    stream_if data_rd ();
    stream_if merged ();

    cobs_segment_encoder encoder (
        .clk           (clk),
        .rst           (rst),
        .s_axis_tdata  (s_axis_tdata),
        .s_axis_tvalid (s_axis_tvalid),
        .s_axis_tlast  (s_axis_tlast),
        .s_axis_tuser  (s_axis_tuser),
        .s_axis_tready (s_axis_tready),
        .code_wr       (code_wr),
        .data_wr       (data_wr)
    );

    // codes and data are queued apart so a code can precede its bytes
    byte_fifo code_fifo (
        .clk (clk),
        .rst (rst),
        .wr  (code_wr),
        .rd  (code_rd)
    );

    byte_fifo data_fifo (
        .clk (clk),
        .rst (rst),
        .wr  (data_wr),
        .rd  (data_rd)
    );

    cobs_output_merger merger (
        .clk     (clk),
        .rst     (rst),
        .code_rd (code_rd),
        .data_rd (data_rd),
        .merged  (merged)
    );

    output_skid_buffer skid (
        .clk           (clk),
        .rst           (rst),
        .merged        (merged),
        .m_axis_tdata  (m_axis_tdata),
        .m_axis_tvalid (m_axis_tvalid),
        .m_axis_tlast  (m_axis_tlast),
        .m_axis_tuser  (m_axis_tuser),
        .m_axis_tready (m_axis_tready)
    );

endmodule

// ==== cobs_encoder_asserts.sv ====
// ****************************************
// handshake and framing properties of the encoder
// bound into cobs_encoder by the testbench
// ****************************************
module cobs_encoder_asserts import stream_pkg::*, cobs_pkg::*; (
    input logic       clk,
    input logic       rst,
    input byte_t      m_axis_tdata,
    input logic       m_axis_tvalid,
    input logic       m_axis_tlast,
    input logic       m_axis_tuser,
    input logic       m_axis_tready,
    input logic       s_axis_tvalid,
    input logic       s_axis_tlast,
    input logic       s_axis_tready,
    input enc_state_t enc_state
);
    timeunit 1ns;
    timeprecision 100ps;

    // read by the testbench top at the end of the run
    int fail_count = 0;

    reset_clears_valid: assert property (@(posedge clk) rst |=> !m_axis_tvalid)
        else begin
            fail_count++;
            $error("m_axis_tvalid high right after a reset cycle");
        end

    // output byte must hold while the sink stalls
    hold_while_stalled: assert property (@(posedge clk) disable iff (rst)
        m_axis_tvalid && !m_axis_tready |=>
            m_axis_tvalid && $stable(m_axis_tdata) && $stable(m_axis_tlast) &&
            $stable(m_axis_tuser))
        else begin
            fail_count++;
            $error("output byte changed while stalled");
        end

    // last input byte moves the encoder into a closing state with input held off
    closing_blocks_input: assert property (@(posedge clk) disable iff (rst)
        s_axis_tvalid && s_axis_tready && s_axis_tlast |=>
            (enc_state == enc_final_zero || enc_state == enc_append_zero) &&
            !s_axis_tready)
        else begin
            fail_count++;
            $error("encoder did not hold off input while writing closing codes");
        end

    user_only_on_last: assert property (@(posedge clk) disable iff (rst)
        m_axis_tvalid && m_axis_tuser |-> m_axis_tlast)
        else begin
            fail_count++;
            $error("m_axis_tuser high on a byte without m_axis_tlast");
        end

endmodule

// ==== cobs_checker.sv ====
// ****************************************
// output scoreboard, loads expected bytes from cobs_cases.txt
// compares every output transfer in order and counts errors
// ****************************************
module cobs_checker import stream_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  byte_t m_axis_tdata,
    input  logic  m_axis_tvalid,
    input  logic  m_axis_tlast,
    input  logic  m_axis_tuser,
    input  logic  m_axis_tready,
    input  logic  run_done,
    output int    errors,
    output int    checks,
    output int    pending
);
    timeunit 1ns;
    timeprecision 100ps;

    byte_t exp_data [$];
    logic  exp_last [$];
    logic  exp_user [$];
    string exp_name [$];
    string cur_name;
    byte_t cur_data;
    logic  cur_last;
    logic  cur_user;

    task automatic add_expected(int value, string name);
        exp_data.push_back(byte_t'(value));
        exp_last.push_back(1'b0);
        exp_user.push_back(1'b0);
        exp_name.push_back(name);
    endtask

    task automatic load_expected();
        int    fd;
        int    n;
        int    i;
        int    pct;
        int    cnt;
        int    start;
        int    value;
        int    user_flag;
        bit    in_out;
        string tok;
        string name;
        fd = $fopen("cobs_cases.txt", "r");
        if (fd == 0) begin
            $display("the checker could not open cobs_cases.txt");
            errors++;
            return;
        end
        in_out = 1'b0;
        user_flag = 0;
        while ($fscanf(fd, "%s", tok) == 1) begin
            if (tok == "#") begin
                n = $fgets(tok, fd);
            end else if (tok == "case") begin
                n = $fscanf(fd, "%s %d", name, pct);
            end else if (tok == "out") begin
                n = $fscanf(fd, "%d", user_flag);
                in_out = 1'b1;
            end else if (tok == "end") begin
                // delimiter closes the frame
                if (in_out && exp_data.size() > 0) begin
                    exp_last[exp_last.size()-1] = 1'b1;
                    exp_user[exp_user.size()-1] = (user_flag != 0);
                end
                in_out = 1'b0;
            end else if (in_out && tok == "run") begin
                n = $fscanf(fd, "%d %h", cnt, start);
                for (i = 0; i < cnt; i++) begin
                    add_expected(((start - 1 + i) % 255) + 1, name);
                end
            end else if (in_out) begin
                n = $sscanf(tok, "%h", value);
                add_expected(value, name);
            end
        end
        $fclose(fd);
    endtask

    task automatic compare_field(string test, string field, logic [7:0] expected,
                                 logic [7:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("CHECK FAILED %s %s expected %0h actual %0h", test, field, expected, actual);
        end
    endtask

    initial begin
        errors = 0;
        checks = 0;
        load_expected();
        pending = exp_data.size();
    end

    always @(posedge clk) begin
        if (!rst && m_axis_tvalid && m_axis_tready) begin
            if (exp_data.size() == 0) begin
                $display("output byte %0h arrived after all expected bytes", m_axis_tdata);
                errors++;
            end else begin
                cur_name = exp_name.pop_front();
                cur_data = exp_data.pop_front();
                cur_last = exp_last.pop_front();
                cur_user = exp_user.pop_front();
                compare_field(cur_name, "data", cur_data, m_axis_tdata);
                compare_field(cur_name, "last", cur_last, m_axis_tlast);
                compare_field(cur_name, "user", cur_user, m_axis_tuser);
            end
            pending = exp_data.size();
        end
    end

    always @(posedge run_done) begin
        if (exp_data.size() != 0) begin
            $display("frame of test %s left incomplete, %0d expected bytes never came out",
                     exp_name[0], exp_data.size());
            errors++;
        end
    end

endmodule

// ==== tb_cobs_encoder.sv ====
// ****************************************
// testbench for the COBS encoder, frames from cobs_cases.txt
// random output back-pressure, watchdog on run length
// ****************************************
module tb_cobs_encoder import stream_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int PERIOD = 40;

    logic  clk;
    logic  rst;
    byte_t s_axis_tdata;
    logic  s_axis_tvalid;
    logic  s_axis_tlast;
    logic  s_axis_tuser;
    logic  s_axis_tready;
    byte_t m_axis_tdata;
    logic  m_axis_tvalid;
    logic  m_axis_tlast;
    logic  m_axis_tuser;
    logic  m_axis_tready;
    logic  run_done;
    int    output_errors;
    int    output_checks;
    int    pending;
    int    tb_errors;
    int    stall_pct;
    int    limit_ns = 0;

    byte_t in_data [$];
    logic  in_last [$];
    logic  in_user [$];
    int    in_pct [$];

    cobs_encoder DUT (
        .clk           (clk),
        .rst           (rst),
        .s_axis_tdata  (s_axis_tdata),
        .s_axis_tvalid (s_axis_tvalid),
        .s_axis_tlast  (s_axis_tlast),
        .s_axis_tuser  (s_axis_tuser),
        .s_axis_tready (s_axis_tready),
        .m_axis_tdata  (m_axis_tdata),
        .m_axis_tvalid (m_axis_tvalid),
        .m_axis_tlast  (m_axis_tlast),
        .m_axis_tuser  (m_axis_tuser),
        .m_axis_tready (m_axis_tready)
    );

    cobs_checker output_check (
        .clk           (clk),
        .rst           (rst),
        .m_axis_tdata  (m_axis_tdata),
        .m_axis_tvalid (m_axis_tvalid),
        .m_axis_tlast  (m_axis_tlast),
        .m_axis_tuser  (m_axis_tuser),
        .m_axis_tready (m_axis_tready),
        .run_done      (run_done),
        .errors        (output_errors),
        .checks        (output_checks),
        .pending       (pending)
    );

    bind cobs_encoder cobs_encoder_asserts asserts (
        .clk           (clk),
        .rst           (rst),
        .m_axis_tdata  (m_axis_tdata),
        .m_axis_tvalid (m_axis_tvalid),
        .m_axis_tlast  (m_axis_tlast),
        .m_axis_tuser  (m_axis_tuser),
        .m_axis_tready (m_axis_tready),
        .s_axis_tvalid (s_axis_tvalid),
        .s_axis_tlast  (s_axis_tlast),
        .s_axis_tready (s_axis_tready),
        .enc_state     (encoder.state)
    );

    task automatic add_input(int value, int pct);
        in_data.push_back(byte_t'(value));
        in_last.push_back(1'b0);
        in_user.push_back(1'b0);
        in_pct.push_back(pct);
    endtask

    task automatic load_frames();
        int    fd;
        int    n;
        int    i;
        int    pct;
        int    cnt;
        int    start;
        int    value;
        int    user_flag;
        bit    in_frame;
        string tok;
        fd = $fopen("cobs_cases.txt", "r");
        if (fd == 0) begin
            $display("the testbench could not open cobs_cases.txt");
            tb_errors++;
            return;
        end
        in_frame = 1'b0;
        pct = 0;
        user_flag = 0;
        while ($fscanf(fd, "%s", tok) == 1) begin
            if (tok == "#") begin
                n = $fgets(tok, fd);
            end else if (tok == "case") begin
                n = $fscanf(fd, "%s %d", tok, pct);
            end else if (tok == "in") begin
                n = $fscanf(fd, "%d", user_flag);
                in_frame = 1'b1;
            end else if (tok == "end") begin
                if (in_frame && in_data.size() > 0) begin
                    in_last[in_last.size()-1] = 1'b1;
                    in_user[in_user.size()-1] = (user_flag != 0);
                end
                in_frame = 1'b0;
            end else if (in_frame && tok == "run") begin
                n = $fscanf(fd, "%d %h", cnt, start);
                for (i = 0; i < cnt; i++) begin
                    add_input(((start - 1 + i) % 255) + 1, pct);
                end
            end else if (in_frame) begin
                n = $sscanf(tok, "%h", value);
                add_input(value, pct);
            end
        end
        $fclose(fd);
    endtask

    function automatic int total_errors();
        return output_errors + tb_errors + DUT.asserts.fail_count;
    endfunction

    task automatic report_counts();
        $display("error counts: checker %0d, testbench %0d, assertions %0d, checks done %0d",
                 output_errors, tb_errors, DUT.asserts.fail_count, output_checks);
    endtask

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // output back-pressure, stall rate follows the frame being sent
    initial begin
        int seed_ret;
        seed_ret = $urandom(94);
        m_axis_tready = 1'b0;
        forever begin
            @(posedge clk);
            #2;
            m_axis_tready = (($urandom % 100) >= stall_pct);
        end
    end

    initial begin
        wait (limit_ns > 0);
        #(limit_ns);
        $display("timeout, the encoder output did not finish within %0d ns", limit_ns);
        tb_errors++;
        report_counts();
        $display("Finished with errors");
        $finish;
    end

    initial begin
        int idx;
        rst           = 1'b1;
        run_done      = 1'b0;
        s_axis_tdata  = '0;
        s_axis_tvalid = 1'b0;
        s_axis_tlast  = 1'b0;
        s_axis_tuser  = 1'b0;
        stall_pct     = 0;
        tb_errors     = 0;
        idx           = 0;
        load_frames();
        if (in_data.size() == 0) begin
            $display("no input frames were found in the cases file");
            tb_errors++;
        end
        limit_ns = in_data.size() * 10 * PERIOD + 2000;
        repeat (4) @(posedge clk);
        #2;
        rst = 1'b0;
        // ready only changes on clock edges, so it is safe to test here
        while (idx < in_data.size()) begin
            if (s_axis_tready) begin
                stall_pct     = in_pct[idx];
                s_axis_tdata  = in_data[idx];
                s_axis_tlast  = in_last[idx];
                s_axis_tuser  = in_user[idx];
                s_axis_tvalid = 1'b1;
                idx++;
            end else begin
                s_axis_tvalid = 1'b0;
            end
            @(posedge clk);
            #2;
        end
        s_axis_tvalid = 1'b0;
        s_axis_tlast  = 1'b0;
        s_axis_tuser  = 1'b0;
        while (pending != 0) begin
            @(posedge clk);
        end
        // catch any extra bytes behind the last delimiter
        repeat (20) @(posedge clk);
        run_done = 1'b1;
        #1;
        report_counts();
        if (total_errors() == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+.
stream_pkg.sv
cobs_pkg.sv
stream_if.sv
byte_fifo.sv
cobs_segment_encoder.sv
cobs_output_merger.sv
output_skid_buffer.sv
cobs_encoder.sv
cobs_encoder_asserts.sv
cobs_checker.sv
tb_cobs_encoder.sv

// ==== cobs_cases.txt ====
# case <name> <percent of cycles with m_axis_tready low>, in <user flag of last byte> <hex bytes> end
# out <user flag on delimiter> <expected hex bytes> end, run <n> <hex> = n bytes counting up, 00 skipped
case stuff_zeros 0 in 0 11 22 00 33 end
out 0 03 11 22 02 33 00 end
case lone_zero 25 in 0 00 end
out 0 01 01 00 end
case trailing_zero 30 in 0 11 00 end
out 0 02 11 01 00 end
case bad_frame 40 in 1 11 22 33 end
out 1 03 11 22 02 00 end
case run_254 10 in 0 run 254 01 end
out 0 FF run 254 01 00 end
case run_300 50 in 0 run 300 01 end
out 0 FF run 254 01 2F run 46 FF 00 end
case bad_after_zero 60 in 1 00 44 end
out 1 01 01 02 00 end
